/* include/fetch_cfg.svh */
// Build-time configuration for the fetch subsystem, included by the package and the RTL
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// Width of every fetch address and pc
`define FETCH_ADDR_W 32

// First fetch address out of reset
`define FETCH_RESET_VEC 32'h0000_0000

// Instruction buffer entries, also the cap on fetches in flight
`define FETCH_BUF_DEPTH 4

// On-chip scratch memory size in 32-bit words
`define SCRATCH_WORDS 64

// Word address width of the scratch memory
`define SCRATCH_AW 6

// Byte addresses below this go to the scratch memory
`define SCRATCH_LIMIT (`SCRATCH_WORDS * 4)

`endif

/* design/fetch_pkg.sv */
// Fetch types shared by the pc stage, the tracking FIFO and the instruction buffer
`include "fetch_cfg.svh"

package fetch_pkg;

    // Which memory sub-unit serves a fetch
    typedef enum logic [0:0] {
        SUB_SCRATCH = 1'b0,
        SUB_EXT     = 1'b1
    } sub_id_t;

    // Instruction buffer entry
    typedef struct packed {
        logic [31:0]               inst;
        logic [`FETCH_ADDR_W-1:0]  pc;
    } fetch_entry_t;

    // Tracking entry for a fetch in flight
    // pc rides along so the returned word can be paired with it
    typedef struct packed {
        sub_id_t                   id;
        logic [`FETCH_ADDR_W-1:0]  pc;
    } fetch_tag_t;

endpackage

/* design/fetch_sub_if.sv */
// Request and return signals between the pc stage and one memory sub-unit
`timescale 1ns/100ps
`include "fetch_cfg.svh"

interface fetch_sub_if;

    // Stage to sub-unit
    logic                      new_request;
    logic [`FETCH_ADDR_W-1:0]  addr;
    logic                      flush;

    // Sub-unit to stage
    logic                      ready;
    logic                      data_valid;
    logic [31:0]               data_out;

    modport stage (
        output new_request, addr, flush,
        input  ready, data_valid, data_out
    );

    modport unit (
        input  new_request, addr, flush,
        output ready, data_valid, data_out
    );

endinterface

/* design/fetch_fifo.sv */
// Small synchronous FIFO for any payload type, used for fetch tracking and the instruction buffer
`timescale 1ns/100ps

module fetch_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     flush,
    input  logic     push,
    input  payload_t data_in,
    input  logic     pop,
    output payload_t data_out,
    output logic     valid
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         entries [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             do_pop;

    // Wraps at DEPTH so non power of two depths work too
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign do_pop = pop & valid;

    always_ff @(posedge clk) begin
        if (flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count <= count + CNT_W'(push) - CNT_W'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= data_in;
        end
    end

    assign valid    = (count != '0);
    assign data_out = entries[rd_ptr];

endmodule

/* design/fetch_pc_stage.sv */
// Fetch pc register, next-address choice, slot accounting and request issue to the sub-units
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module fetch_pc_stage
    import fetch_pkg::*;
(
    input  logic                      clk,
    input  logic                      flush_or_rst,
    input  logic                      redirect,
    input  logic [`FETCH_ADDR_W-1:0]  redirect_pc,
    input  logic                      inst_pop,
    output logic                      id_push,
    output sub_id_t                   id_in,
    output logic [`FETCH_ADDR_W-1:0]  fetch_pc,
    fetch_sub_if.stage                scratch,
    fetch_sub_if.stage                ext
);

    localparam int SLOT_W = $clog2(`FETCH_BUF_DEPTH + 1);

    logic [`FETCH_ADDR_W-1:0] pc;
    logic [`FETCH_ADDR_W-1:0] next_pc;
    logic [SLOT_W-1:0]        free_slots;
    logic                     flush;
    logic                     sel_ext;
    logic                     units_ready;
    logic                     slot_free;
    logic                     issue;

    ////////////////////////////////////////////////////////////////////////////
    // Program counter

    // Redirect beats sequential
    assign next_pc = redirect ? redirect_pc : pc + `FETCH_ADDR_W'(4);

    always_ff @(posedge clk) begin
        if (flush_or_rst) begin
            pc <= `FETCH_RESET_VEC;
        end else if (redirect | issue) begin
            pc <= {next_pc[`FETCH_ADDR_W-1:2], 2'b00};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Issue control

    assign flush       = flush_or_rst | redirect;
    assign units_ready = scratch.ready & ext.ready;
    assign slot_free   = (free_slots != '0);

    // Stale pc during a flush, so hold off
    assign issue = units_ready & slot_free & ~flush;

    // Counts buffer entries plus fetches in flight against the depth
    always_ff @(posedge clk) begin
        if (flush) begin
            free_slots <= SLOT_W'(`FETCH_BUF_DEPTH);
        end else begin
            free_slots <= free_slots - SLOT_W'(issue) + SLOT_W'(inst_pop);
        end
    end

    // Address decode
    assign sel_ext = (pc >= `FETCH_ADDR_W'(`SCRATCH_LIMIT));

    ////////////////////////////////////////////////////////////////////////////
    // Sub-unit requests and tracking

    assign scratch.new_request = issue & ~sel_ext;
    assign scratch.addr        = pc;
    assign scratch.flush       = flush;

    assign ext.new_request = issue & sel_ext;
    assign ext.addr        = pc;
    assign ext.flush       = flush;

    assign id_push  = issue;
    assign id_in    = sel_ext ? SUB_EXT : SUB_SCRATCH;
    assign fetch_pc = pc;

endmodule

/* design/scratch_fetch_unit.sv */
// On-chip instruction scratch memory with a load port and a one-cycle fetch read
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module scratch_fetch_unit (
    input  logic                    clk,
    input  logic                    flush_or_rst,
    input  logic                    load_en,
    input  logic [`SCRATCH_AW-1:0]  load_addr,
    input  logic [31:0]             load_data,
    fetch_sub_if.unit               sub
);

    logic [31:0]            mem [`SCRATCH_WORDS];
    logic [31:0]            rd_data;
    logic [`SCRATCH_AW-1:0] rd_addr;
    logic                   data_valid_r;

    // Word index out of the byte address
    assign rd_addr = sub.addr[`SCRATCH_AW+1:2];

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    always_ff @(posedge clk) begin
        if (sub.new_request) begin
            rd_data <= mem[rd_addr];
        end
    end

    // A request that meets a flush never returns
    always_ff @(posedge clk) begin
        if (flush_or_rst) begin
            data_valid_r <= 1'b0;
        end else begin
            data_valid_r <= sub.new_request & ~sub.flush;
        end
    end

    // Single cycle memory never stalls
    assign sub.ready      = 1'b1;
    assign sub.data_valid = data_valid_r;
    assign sub.data_out   = rd_data;

endmodule

/* design/ext_fetch_port.sv */
// Fetch sub-unit that runs each request as a four-phase req/ack transaction to outside memory
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module ext_fetch_port (
    input  logic                      clk,
    input  logic                      flush_or_rst,
    input  logic                      mem_ack,
    input  logic [31:0]               mem_data,
    output logic                      mem_req,
    output logic [`FETCH_ADDR_W-1:0]  mem_addr,
    fetch_sub_if.unit                 sub
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_ACK_LOW
    } port_state_t;

    port_state_t              state;
    logic [`FETCH_ADDR_W-1:0] addr_q;
    logic [31:0]              data_q;
    logic                     discard;
    logic                     data_valid_r;
    logic                     accept;
    logic                     ack_seen;
    logic                     ack_released;

    assign accept       = (state == ST_IDLE) & sub.new_request;
    assign ack_seen     = (state == ST_REQ) & mem_ack;
    assign ack_released = (state == ST_ACK_LOW) & ~mem_ack;

    ////////////////////////////////////////////////////////////////////////////
    // Handshake FSM

    always_ff @(posedge clk) begin
        if (flush_or_rst) begin
            state        <= ST_IDLE;
            data_valid_r <= 1'b0;
        end else begin
            data_valid_r <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (sub.new_request) begin
                        state <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (mem_ack) begin
                        state        <= ST_ACK_LOW;
                        data_valid_r <= ~discard & ~sub.flush;
                    end
                end
                ST_ACK_LOW: begin
                    // Next req only after ack has dropped
                    if (~mem_ack) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Flush mid-transaction; the handshake still finishes but its word is dropped
    always_ff @(posedge clk) begin
        if (flush_or_rst) begin
            discard <= 1'b0;
        end else if (ack_released) begin
            discard <= 1'b0;
        end else if (sub.flush && state != ST_IDLE) begin
            discard <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Address and returned word

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= sub.addr;
        end
        if (ack_seen) begin
            data_q <= mem_data;
        end
    end

    assign mem_req  = (state == ST_REQ);
    assign mem_addr = addr_q;

    assign sub.ready      = (state == ST_IDLE);
    assign sub.data_valid = data_valid_r;
    assign sub.data_out   = data_q;

endmodule

/* design/fetch_unit.sv */
// Instruction fetch top level; connects pc stage, sub-units and FIFOs behind plain ports
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module fetch_unit
    import fetch_pkg::*;
(
    input  logic                      clk,
    input  logic                      flush_or_rst,
    input  logic                      redirect,
    input  logic [`FETCH_ADDR_W-1:0]  redirect_pc,
    input  logic                      load_en,
    input  logic [`SCRATCH_AW-1:0]    load_addr,
    input  logic [31:0]               load_data,
    input  logic                      mem_ack,
    input  logic [31:0]               mem_data,
    input  logic                      inst_pop,
    output logic                      mem_req,
    output logic [`FETCH_ADDR_W-1:0]  mem_addr,
    output logic                      inst_valid,
    output logic [31:0]               inst,
    output logic [`FETCH_ADDR_W-1:0]  inst_pc
);

    fetch_sub_if scratch_sub ();
    fetch_sub_if ext_sub ();

    logic                     fifo_flush;
    logic                     id_push;
    sub_id_t                  id_in;
    logic [`FETCH_ADDR_W-1:0] fetch_pc;
    fetch_tag_t               tag_in;
    fetch_tag_t               tag_out;
    logic                     tag_valid;
    logic                     ret_valid;
    fetch_entry_t             ret_entry;
    fetch_entry_t             buf_out;

    assign fifo_flush = flush_or_rst | redirect;

    ////////////////////////////////////////////////////////////////////////////
    // Stages

    fetch_pc_stage pc_stage (
        .clk          (clk),
        .flush_or_rst (flush_or_rst),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .inst_pop     (inst_pop),
        .id_push      (id_push),
        .id_in        (id_in),
        .fetch_pc     (fetch_pc),
        .scratch      (scratch_sub.stage),
        .ext          (ext_sub.stage)
    );

    scratch_fetch_unit scratch_unit (
        .clk          (clk),
        .flush_or_rst (flush_or_rst),
        .load_en      (load_en),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .sub          (scratch_sub.unit)
    );

    ext_fetch_port ext_port (
        .clk          (clk),
        .flush_or_rst (flush_or_rst),
        .mem_ack      (mem_ack),
        .mem_data     (mem_data),
        .mem_req      (mem_req),
        .mem_addr     (mem_addr),
        .sub          (ext_sub.unit)
    );

    ////////////////////////////////////////////////////////////////////////////
    // In-order return tracking

    assign tag_in = '{id: id_in, pc: fetch_pc};

    fetch_fifo #(
        .payload_t (fetch_tag_t),
        .DEPTH     (2)
    ) id_fifo (
        .clk      (clk),
        .flush    (fifo_flush),
        .push     (id_push),
        .data_in  (tag_in),
        .pop      (ret_valid),
        .data_out (tag_out),
        .valid    (tag_valid)
    );

    // Head tag names the unit that answers next
    assign ret_valid      = (scratch_sub.data_valid | ext_sub.data_valid) & tag_valid;
    assign ret_entry.inst = (tag_out.id == SUB_EXT) ? ext_sub.data_out : scratch_sub.data_out;
    assign ret_entry.pc   = tag_out.pc;

    fetch_fifo #(
        .payload_t (fetch_entry_t),
        .DEPTH     (`FETCH_BUF_DEPTH)
    ) inst_buf (
        .clk      (clk),
        .flush    (fifo_flush),
        .push     (ret_valid),
        .data_in  (ret_entry),
        .pop      (inst_pop),
        .data_out (buf_out),
        .valid    (inst_valid)
    );

    assign inst    = buf_out.inst;
    assign inst_pc = buf_out.pc;

endmodule

/* verification/ext_mem_responder.sv */
// External memory model for the fetch testbench; answers four-phase req/ack with a computed word
`timescale 1ns/100ps

module ext_mem_responder #(
    parameter logic [31:0] SEED     = 32'd11083,
    parameter logic [31:0] DATA_KEY = 32'hA5A5_0000,
    parameter int          MAX_WAIT = 5
) (
    input  logic        clk,
    input  logic        mem_req,
    input  logic [31:0] mem_addr,
    output logic        mem_ack,
    output logic [31:0] mem_data
);

    logic [31:0] lcg_state;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Random wait of 0 to MAX_WAIT cycles, ends half a ns after an edge
    task automatic hold_cycles();
        int n;
        lcg_state = lcg_next(lcg_state);
        n = int'({16'd0, lcg_state[31:16]}) % (MAX_WAIT + 1);
        repeat (n) begin
            @(posedge clk);
            #0.5;
        end
    endtask

    initial begin
        lcg_state = SEED;
        mem_ack   = 1'b0;
        mem_data  = '0;
        forever begin
            @(posedge clk);
            #0.5;
            if (mem_req && !mem_ack) begin
                hold_cycles();
                mem_data = mem_addr ^ DATA_KEY;
                mem_ack  = 1'b1;
                // Port drops req once it has taken the word
                while (mem_req) begin
                    @(posedge clk);
                    #0.5;
                end
                hold_cycles();
                mem_ack = 1'b0;
            end
        end
    end

endmodule

/* verification/fetch_tb.sv */
// Testbench top for the fetch subsystem; runs a table of fetch scenarios against a reference model
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module fetch_tb;

    localparam logic [31:0] EXT_KEY  = 32'hA5A5_0000;
    localparam logic [31:0] LCG_SEED = 32'd11083;
    localparam int          NUM_ROWS = 8;

    // Optional redirect, instructions to take, stall before the first pop
    typedef struct packed {
        logic        redir;
        logic        on_req;
        logic [31:0] start_pc;
        logic [7:0]  count;
        logic [7:0]  stall;
        logic        chk_fill;
    } row_t;

    localparam row_t ROWS [NUM_ROWS] = '{
        '{1'b0, 1'b0, `FETCH_RESET_VEC, 8'd12, 8'd0, 1'b0},
        '{1'b1, 1'b0, 32'h0000_1000, 8'd8, 8'd0, 1'b0},
        '{1'b1, 1'b0, 32'(`SCRATCH_LIMIT - 16), 8'd10, 8'd0, 1'b0},
        '{1'b1, 1'b0, 32'h0000_2000, 8'd8, 8'd80, 1'b1},
        '{1'b1, 1'b0, 32'h0000_0040, 8'd10, 8'd12, 1'b0},
        '{1'b1, 1'b0, 32'h0000_3000, 8'd3, 8'd0, 1'b0},
        '{1'b1, 1'b1, 32'(`SCRATCH_LIMIT - 8), 8'd6, 8'd0, 1'b0},
        '{1'b1, 1'b1, 32'h0000_1100, 8'd5, 8'd0, 1'b0}
    };

    logic        clk;
    logic        flush_or_rst;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic        load_en;
    logic [`SCRATCH_AW-1:0] load_addr;
    logic [31:0] load_data;
    logic        mem_ack;
    logic [31:0] mem_data;
    logic        inst_pop;
    logic        mem_req;
    logic [31:0] mem_addr;
    logic        inst_valid;
    logic [31:0] inst;
    logic [31:0] inst_pc;

    logic [31:0] scratch_model [`SCRATCH_WORDS];
    int          inst_errors;
    int          fill_errors;

    fetch_unit dut (.*);

    ext_mem_responder #(
        .SEED     (LCG_SEED),
        .DATA_KEY (EXT_KEY)
    ) mem_model (
        .clk      (clk),
        .mem_req  (mem_req),
        .mem_addr (mem_addr),
        .mem_ack  (mem_ack),
        .mem_data (mem_data)
    );

    always #2 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Model and helpers

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] expected_word(input logic [31:0] pc);
        if (pc < `SCRATCH_LIMIT) begin
            return scratch_model[pc[`SCRATCH_AW+1:2]];
        end
        return pc ^ EXT_KEY;
    endfunction

    // About 20 cycles per instruction plus slack for reset and preload
    function automatic int watchdog_cycles();
        int total;
        total = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            total += int'(ROWS[i].count);
        end
        return total * 20 + 200;
    endfunction

    // Half a ns past the next rising edge
    task automatic step();
        @(posedge clk);
        #0.5;
    endtask

    task automatic preload_scratch();
        logic [31:0] rnd;
        rnd = LCG_SEED;
        for (int i = 0; i < `SCRATCH_WORDS; i++) begin
            rnd              = lcg_next(rnd);
            scratch_model[i] = rnd;
            load_en          = 1'b1;
            load_addr        = `SCRATCH_AW'(i);
            load_data        = rnd;
            step();
        end
        load_en = 1'b0;
    endtask

    task automatic check_inst(input logic [31:0] exp_pc);
        logic [31:0] exp_word;
        exp_word = expected_word(exp_pc);
        assert (inst_pc == exp_pc) else begin
            inst_errors++;
            $display("[FAIL] %0.1f ns inst_pc: got %h, expected %h", $realtime, inst_pc, exp_pc);
        end
        assert (inst == exp_word) else begin
            inst_errors++;
            $display("[FAIL] %0.1f ns inst: got %h, expected %h", $realtime, inst, exp_word);
        end
    endtask

    // Pops whenever a word is there, in pc order
    task automatic consume_insts(input logic [31:0] first_pc, input int count);
        logic [31:0] exp_pc;
        int          taken;
        exp_pc = first_pc;
        taken  = 0;
        while (taken < count) begin
            if (inst_valid) begin
                check_inst(exp_pc);
                inst_pop = 1'b1;
                exp_pc   = exp_pc + 32'd4;
                taken++;
            end else begin
                inst_pop = 1'b0;
            end
            step();
        end
        inst_pop = 1'b0;
    endtask

    task automatic run_row(input row_t row);
        int   rises;
        logic prev_req;
        if (row.redir) begin
            // Hit the port in the middle of a transaction
            if (row.on_req) begin
                while (!mem_req) begin
                    step();
                end
            end
            redirect    = 1'b1;
            redirect_pc = row.start_pc;
            step();
            redirect = 1'b0;
        end
        rises    = 0;
        prev_req = mem_req;
        repeat (row.stall) begin
            step();
            if (mem_req && !prev_req) begin
                rises++;
            end
            prev_req = mem_req;
        end
        if (row.chk_fill) begin
            assert (rises == `FETCH_BUF_DEPTH) else begin
                fill_errors++;
                $display("[FAIL] %0.1f ns mem_req rises during stall: got %0d, expected %0d",
                         $realtime, rises, `FETCH_BUF_DEPTH);
            end
        end
        consume_insts(row.start_pc, int'(row.count));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence and watchdog

    initial begin
        clk          = 1'b0;
        flush_or_rst = 1'b1;
        redirect     = 1'b0;
        redirect_pc  = '0;
        load_en      = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        inst_pop     = 1'b0;
        inst_errors  = 0;
        fill_errors  = 0;
        step();
        // Scratch fills while the core is held in reset
        preload_scratch();
        repeat (10) step();
        flush_or_rst = 1'b0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(ROWS[i]);
        end
        $display("Errors: instruction %0d, buffer fill %0d", inst_errors, fill_errors);
        if (inst_errors == 0 && fill_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles()) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", watchdog_cycles());
        $display("Errors: instruction %0d, buffer fill %0d", inst_errors, fill_errors);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* sim.f */
+incdir+include
design/fetch_pkg.sv
design/fetch_sub_if.sv
design/fetch_fifo.sv
design/fetch_pc_stage.sv
design/scratch_fetch_unit.sv
design/ext_fetch_port.sv
design/fetch_unit.sv
verification/ext_mem_responder.sv
verification/fetch_tb.sv

/* Makefile */
# Verilator build and run of the fetch subsystem testbench

SRCS := $(shell grep -v '^+' sim.f) include/fetch_cfg.svh

obj_dir/Vfetch_tb: sim.f $(SRCS)
	verilator --binary --timing --assert --top-module fetch_tb -f sim.f -o Vfetch_tb

run: obj_dir/Vfetch_tb
	./obj_dir/Vfetch_tb | tee sim.log
	$(MAKE) check

# The log decides the result
check:
	@if grep -q "Simulation failed" sim.log; then exit 1; fi
	@grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run check clean
